// File: common/ssb_sync_pkg.sv
package ssb_sync_pkg;

    // ----------------------------------------
    // Sample and metric widths
    // ----------------------------------------
    typedef logic signed [15:0] iq_comp_t;
    typedef logic        [23:0] metric_t;

    typedef struct packed {
        iq_comp_t im;   // Upper half of the word
        iq_comp_t re;
    } iq_sample_t;

    typedef struct packed {
        iq_sample_t data;
        logic       valid;
    } sample_strm_t;

    typedef struct packed {
        iq_sample_t data;
        logic       valid;
        logic       symbol_start;
        logic       ssb_start;
    } framed_strm_t;

    // ----------------------------------------
    // CIC decimator
    // ----------------------------------------
    localparam int CIC_RATE   = 2;
    localparam int CIC_ORDER  = 2;
    localparam int CIC_GROWTH = 2;   // ORDER * log2(RATE)

    typedef logic signed [$bits(iq_comp_t)+CIC_GROWTH-1:0] cic_acc_t;

    // ----------------------------------------
    // PSS correlation and peak search
    // ----------------------------------------
    localparam int              PSS_LEN        = 16;
    localparam logic [PSS_LEN-1:0] PSS_TAPS    = 16'b0001_1110_0011_0101; // Bit 0 is newest
    localparam metric_t         PEAK_THRESHOLD = 24'd300_000;
    localparam int              PEAK_HOLDOFF   = 32;

    typedef logic signed [$bits(iq_comp_t)+$clog2(PSS_LEN):0] corr_sum_t;
    typedef logic [$clog2(PEAK_HOLDOFF+1)-1:0]                holdoff_cnt_t;

    // ----------------------------------------
    // SSB framing
    // ----------------------------------------
    localparam int SYM_LEN      = 32;
    localparam int SYMS_PER_SSB = 4;
    localparam int DELAY_LEN    = 40;   // Clock cycles

    typedef logic [$clog2(SYM_LEN)-1:0]      samp_idx_t;
    typedef logic [$clog2(SYMS_PER_SSB)-1:0] sym_idx_t;

    typedef enum logic [0:0] {
        IDLE,
        SYMBOLS
    } frame_state_e;

endpackage

// File: source/cic_decimator.sv
`timescale 1ns/1ps

module cic_decimator (
    input  logic                       clk_i,
    input  logic                       reset_ni,
    input  ssb_sync_pkg::sample_strm_t s_i,
    output ssb_sync_pkg::sample_strm_t s_o
);

    // Index 0 is I, index 1 is Q
    ssb_sync_pkg::iq_comp_t     x [2];
    ssb_sync_pkg::iq_comp_t     y [2];
    ssb_sync_pkg::cic_acc_t     int1_q [2];
    ssb_sync_pkg::cic_acc_t     int2_q [2];
    ssb_sync_pkg::cic_acc_t     int1_d [2];
    ssb_sync_pkg::cic_acc_t     int2_d [2];
    ssb_sync_pkg::cic_acc_t     i2_dec_q [2];  // Last decimated integrator output
    ssb_sync_pkg::cic_acc_t     c1_dec_q [2];  // Last first-comb output
    ssb_sync_pkg::cic_acc_t     comb1 [2];
    ssb_sync_pkg::cic_acc_t     comb2 [2];
    logic                       phase_q;       // High on the sample that is kept
    ssb_sync_pkg::sample_strm_t out_q;

    // ----------------------------------------
    // Integrators at input rate, combs at output rate
    // ----------------------------------------
    always_comb begin
        x[0] = s_i.data.re;
        x[1] = s_i.data.im;
        for (int c = 0; c < 2; c++) begin
            int1_d[c] = int1_q[c] + ssb_sync_pkg::cic_acc_t'(x[c]);
            int2_d[c] = int2_q[c] + int1_d[c];
            comb1[c]  = int2_d[c] - i2_dec_q[c];
            comb2[c]  = comb1[c] - c1_dec_q[c];
            y[c]      = ssb_sync_pkg::iq_comp_t'(comb2[c] >>> ssb_sync_pkg::CIC_GROWTH);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            for (int c = 0; c < 2; c++) begin
                int1_q[c]   <= '0;
                int2_q[c]   <= '0;
                i2_dec_q[c] <= '0;
                c1_dec_q[c] <= '0;
            end
            phase_q     <= 1'b0;
            out_q.valid <= 1'b0;
        end else begin
            out_q.valid <= s_i.valid & phase_q;
            if (s_i.valid) begin
                phase_q <= ~phase_q;
                for (int c = 0; c < 2; c++) begin
                    int1_q[c] <= int1_d[c];
                    int2_q[c] <= int2_d[c];
                    if (phase_q) begin
                        i2_dec_q[c] <= int2_d[c];
                        c1_dec_q[c] <= comb1[c];
                    end
                end
            end
        end
        if (s_i.valid && phase_q) begin
            out_q.data.re <= y[0];
            out_q.data.im <= y[1];
        end
    end

    assign s_o = out_q;

    // Rate 2 means outputs are at least one idle cycle apart
    a_no_back_to_back: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        s_o.valid |=> !s_o.valid
    );

endmodule

// File: pss_detector/pss_correlator.sv
`timescale 1ns/1ps

module pss_correlator (
    input  logic                       clk_i,
    input  logic                       reset_ni,
    input  ssb_sync_pkg::sample_strm_t s_i,
    output ssb_sync_pkg::metric_t      metric_o,
    output logic                       metric_valid_o
);

    ssb_sync_pkg::iq_sample_t win_q [ssb_sync_pkg::PSS_LEN];
    ssb_sync_pkg::iq_sample_t win_d [ssb_sync_pkg::PSS_LEN];  // Window including s_i
    ssb_sync_pkg::corr_sum_t  sum_re_d;
    ssb_sync_pkg::corr_sum_t  sum_im_d;
    ssb_sync_pkg::corr_sum_t  sum_re_q;
    ssb_sync_pkg::corr_sum_t  sum_im_q;
    logic                     sum_valid_q;
    ssb_sync_pkg::metric_t    metric_q;
    logic                     metric_valid_q;

    function automatic ssb_sync_pkg::metric_t magnitude(input ssb_sync_pkg::corr_sum_t v);
        logic signed [$bits(ssb_sync_pkg::metric_t)-1:0] wide;
        wide = v;
        return (wide < 0) ? ssb_sync_pkg::metric_t'(-wide) : ssb_sync_pkg::metric_t'(wide);
    endfunction

    // ----------------------------------------
    // Signed sums over the window
    // ----------------------------------------
    always_comb begin
        win_d[0] = s_i.data;
        for (int k = 1; k < ssb_sync_pkg::PSS_LEN; k++) begin
            win_d[k] = win_q[k-1];
        end
        sum_re_d = '0;
        sum_im_d = '0;
        for (int k = 0; k < ssb_sync_pkg::PSS_LEN; k++) begin
            if (ssb_sync_pkg::PSS_TAPS[k]) begin
                sum_re_d = sum_re_d + ssb_sync_pkg::corr_sum_t'(win_d[k].re);
                sum_im_d = sum_im_d + ssb_sync_pkg::corr_sum_t'(win_d[k].im);
            end else begin
                sum_re_d = sum_re_d - ssb_sync_pkg::corr_sum_t'(win_d[k].re);
                sum_im_d = sum_im_d - ssb_sync_pkg::corr_sum_t'(win_d[k].im);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            for (int k = 0; k < ssb_sync_pkg::PSS_LEN; k++) begin
                win_q[k] <= '0;   // Empty history reads as zeros
            end
            sum_valid_q    <= 1'b0;
            metric_valid_q <= 1'b0;
        end else begin
            if (s_i.valid) begin
                win_q <= win_d;
            end
            sum_valid_q    <= s_i.valid;
            metric_valid_q <= sum_valid_q;
        end
        if (s_i.valid) begin
            sum_re_q <= sum_re_d;
            sum_im_q <= sum_im_d;
        end
        metric_q <= magnitude(sum_re_q) + magnitude(sum_im_q);
    end

    assign metric_o       = metric_q;
    assign metric_valid_o = metric_valid_q;

    a_metric_latency: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        s_i.valid |-> ##2 metric_valid_o
    );

endmodule

// File: pss_detector/pss_peak_detector.sv
`timescale 1ns/1ps

module pss_peak_detector (
    input  logic                  clk_i,
    input  logic                  reset_ni,
    input  ssb_sync_pkg::metric_t metric_i,
    input  logic                  metric_valid_i,
    output logic                  peak_o
);

    ssb_sync_pkg::holdoff_cnt_t holdoff_q;  // Metric strobes still to ignore
    logic                       peak_q;
    logic                       above;

    assign above = (metric_i >= ssb_sync_pkg::PEAK_THRESHOLD);

    // ----------------------------------------
    // Threshold with hold-off
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            holdoff_q <= '0;
            peak_q    <= 1'b0;
        end else begin
            peak_q <= 1'b0;
            if (metric_valid_i) begin
                if (holdoff_q != '0) begin
                    holdoff_q <= holdoff_q - 1'b1;
                end else if (above) begin
                    peak_q    <= 1'b1;
                    holdoff_q <= ssb_sync_pkg::holdoff_cnt_t'(ssb_sync_pkg::PEAK_HOLDOFF);
                end
            end
        end
    end

    assign peak_o = peak_q;

    // Single-cycle pulse even if metric strobes come back to back
    a_peak_pulse: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        peak_o |=> !peak_o
    );

endmodule

// File: source/sample_delay_line.sv
`timescale 1ns/1ps

module sample_delay_line (
    input  logic                       clk_i,
    input  logic                       reset_ni,
    input  ssb_sync_pkg::sample_strm_t s_i,
    output ssb_sync_pkg::sample_strm_t s_o
);

    // Stage 0 holds the sample from one cycle back
    ssb_sync_pkg::sample_strm_t dly_q [ssb_sync_pkg::DELAY_LEN];

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            for (int i = 0; i < ssb_sync_pkg::DELAY_LEN; i++) begin
                dly_q[i] <= '0;
            end
        end else begin
            dly_q[0] <= s_i;
            for (int i = 1; i < ssb_sync_pkg::DELAY_LEN; i++) begin
                dly_q[i] <= dly_q[i-1];
            end
        end
    end

    assign s_o = dly_q[ssb_sync_pkg::DELAY_LEN-1];

endmodule

// File: source/frame_sync.sv
`timescale 1ns/1ps

module frame_sync (
    input  logic                       clk_i,
    input  logic                       reset_ni,
    input  logic                       peak_i,
    input  ssb_sync_pkg::sample_strm_t s_i,
    output ssb_sync_pkg::framed_strm_t out_o
);

    ssb_sync_pkg::frame_state_e state_q;
    ssb_sync_pkg::samp_idx_t    samp_q;   // Sample index inside the symbol
    ssb_sync_pkg::sym_idx_t     sym_q;    // Symbol index inside the SSB
    ssb_sync_pkg::framed_strm_t out_q;
    logic                       last_samp;
    logic                       last_sym;

    assign last_samp = (samp_q == ssb_sync_pkg::samp_idx_t'(ssb_sync_pkg::SYM_LEN - 1));
    assign last_sym  = (sym_q == ssb_sync_pkg::sym_idx_t'(ssb_sync_pkg::SYMS_PER_SSB - 1));

    // ----------------------------------------
    // Symbol cutting FSM
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q            <= ssb_sync_pkg::IDLE;
            samp_q             <= '0;
            sym_q              <= '0;
            out_q.valid        <= 1'b0;
            out_q.symbol_start <= 1'b0;
            out_q.ssb_start    <= 1'b0;
        end else begin
            out_q.valid        <= 1'b0;
            out_q.symbol_start <= 1'b0;
            out_q.ssb_start    <= 1'b0;
            case (state_q)
                ssb_sync_pkg::IDLE: begin
                    samp_q <= '0;
                    sym_q  <= '0;
                    if (peak_i) begin
                        state_q <= ssb_sync_pkg::SYMBOLS;
                    end
                end
                ssb_sync_pkg::SYMBOLS: begin   // Further peaks ignored here
                    if (s_i.valid) begin
                        out_q.valid        <= 1'b1;
                        out_q.symbol_start <= (samp_q == '0);
                        out_q.ssb_start    <= (samp_q == '0) && (sym_q == '0);
                        samp_q             <= samp_q + 1'b1;
                        if (last_samp) begin
                            samp_q <= '0;
                            sym_q  <= sym_q + 1'b1;
                            if (last_sym) begin
                                state_q <= ssb_sync_pkg::IDLE;
                            end
                        end
                    end
                end
                default: state_q <= ssb_sync_pkg::IDLE;
            endcase
        end
        out_q.data <= s_i.data;
    end

    assign out_o = out_q;

    // Every SSB opens after an idle output cycle spent in IDLE
    a_ssb_after_gap: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        out_o.ssb_start |-> !$past(out_o.valid)
    );

endmodule

// File: source/ssb_sync_top.sv
`timescale 1ns/1ps

module ssb_sync_top (
    input  logic                       clk_i,
    input  logic                       reset_ni,
    input  ssb_sync_pkg::sample_strm_t s_i,
    output ssb_sync_pkg::framed_strm_t out_o,
    // Debug taps
    output ssb_sync_pkg::sample_strm_t cic_o,
    output ssb_sync_pkg::metric_t      metric_o,
    output logic                       metric_valid_o,
    output logic                       peak_o
);

    ssb_sync_pkg::sample_strm_t cic_s;
    ssb_sync_pkg::metric_t      metric;
    logic                       metric_valid;
    logic                       peak;
    ssb_sync_pkg::sample_strm_t dly_s;

    // ----------------------------------------
    // Decimated detection path
    // ----------------------------------------
    cic_decimator cic_decimator_inst (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .s_i      (s_i),
        .s_o      (cic_s)
    );

    pss_correlator pss_correlator_inst (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .s_i            (cic_s),
        .metric_o       (metric),
        .metric_valid_o (metric_valid)
    );

    pss_peak_detector pss_peak_detector_inst (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .metric_i       (metric),
        .metric_valid_i (metric_valid),
        .peak_o         (peak)
    );

    // ----------------------------------------
    // Full-rate path
    // ----------------------------------------
    sample_delay_line sample_delay_line_inst (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .s_i      (s_i),
        .s_o      (dly_s)
    );

    frame_sync frame_sync_inst (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .peak_i   (peak),
        .s_i      (dly_s),
        .out_o    (out_o)
    );

    assign cic_o          = cic_s;
    assign metric_o       = metric;
    assign metric_valid_o = metric_valid;
    assign peak_o         = peak;

endmodule

// File: testbench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic clk_o,
    output logic reset_no
);

    initial begin
        clk_o    = 1'b0;
        reset_no = 1'b0;
        repeat (2) @(posedge clk_o);
        reset_no <= 1'b1;   // Released on an edge, seen from the third edge on
    end

    always #10 clk_o = ~clk_o;

endmodule

// File: testbench/tb_ssb_sync_top.sv
`timescale 1ns/1ps

module tb_ssb_sync_top;

    localparam int MAX_CYC   = 4096;
    localparam int SSB_LEN   = ssb_sync_pkg::SYM_LEN * ssb_sync_pkg::SYMS_PER_SSB;
    localparam int PSS_AMP   = 30000;
    localparam int NOISE_AMP = 200;

    typedef struct packed {
        int                         due;   // Cycle the sample must appear
        ssb_sync_pkg::framed_strm_t frm;
    } framed_exp_t;

    logic                       clk_i;
    logic                       reset_ni;
    ssb_sync_pkg::sample_strm_t s_i;
    ssb_sync_pkg::framed_strm_t out_o;
    ssb_sync_pkg::sample_strm_t cic_o;
    ssb_sync_pkg::metric_t      metric_o;
    logic                       metric_valid_o;
    logic                       peak_o;

    int seed           = 32'h5c45;
    int cyc            = 0;
    int pattern_cyc    = MAX_CYC;
    int first_peak_cyc = -1;
    int peak_count     = 0;
    int framed_checked = 0;
    int frames_done    = 0;

    // ----------------------------------------
    // Reference model state
    // ----------------------------------------
    ssb_sync_pkg::sample_strm_t in_s [MAX_CYC];   // Input seen before each edge
    bit                         exp_mv [MAX_CYC];
    ssb_sync_pkg::metric_t      exp_m [MAX_CYC];
    bit                         exp_pk [MAX_CYC];
    int                         xr [3];
    int                         xi [3];
    int                         dr [ssb_sync_pkg::PSS_LEN];   // Index 0 newest
    int                         di [ssb_sync_pkg::PSS_LEN];
    int                         n_in       = 0;
    int                         since_peak = ssb_sync_pkg::PEAK_HOLDOFF;
    bit                         fr_active  = 1'b0;
    int                         fr_idx     = 0;
    framed_exp_t                exp_q [$];

    clock_gen clock_gen_inst (
        .clk_o    (clk_i),
        .reset_no (reset_ni)
    );

    ssb_sync_top ssb_sync_top_inst (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .s_i            (s_i),
        .out_o          (out_o),
        .cic_o          (cic_o),
        .metric_o       (metric_o),
        .metric_valid_o (metric_valid_o),
        .peak_o         (peak_o)
    );

    // (1 + z^-1)^2 at input rate, normalized by the CIC gain
    function automatic ssb_sync_pkg::iq_comp_t cic_ref(input int x0, input int x1, input int x2);
        int acc;
        acc = x0 + 2 * x1 + x2;
        return ssb_sync_pkg::iq_comp_t'(acc >>> ssb_sync_pkg::CIC_GROWTH);
    endfunction

    function automatic ssb_sync_pkg::metric_t metric_ref();
        int sr;
        int si;
        sr = 0;
        si = 0;
        for (int k = 0; k < ssb_sync_pkg::PSS_LEN; k++) begin
            if (ssb_sync_pkg::PSS_TAPS[k]) begin
                sr = sr + dr[k];
                si = si + di[k];
            end else begin
                sr = sr - dr[k];
                si = si - di[k];
            end
        end
        return ssb_sync_pkg::metric_t'((sr < 0 ? -sr : sr) + (si < 0 ? -si : si));
    endfunction

    function automatic bit peak_ref(input ssb_sync_pkg::metric_t m, input int since);
        return (since >= ssb_sync_pkg::PEAK_HOLDOFF) && (m >= ssb_sync_pkg::PEAK_THRESHOLD);
    endfunction

    task automatic abort_run(input string why);
        $display("SOME TESTS FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_sample(input string name, input ssb_sync_pkg::iq_sample_t got,
                                input ssb_sync_pkg::iq_sample_t want);
        if (got !== want) begin
            $display("[FAIL] %0t %s got re=%0d im=%0d expected re=%0d im=%0d",
                     $time, name, got.re, got.im, want.re, want.im);
            abort_run({name, " data mismatch"});
        end
    endtask

    task automatic check_metric(input string name, input ssb_sync_pkg::metric_t got,
                                input ssb_sync_pkg::metric_t want);
        if (got !== want) begin
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, want);
            abort_run({name, " value mismatch"});
        end
    endtask

    task automatic check_strobe(input string name, input logic got, input bit want);
        if (got !== want) begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, want);
            abort_run({name, " strobe mismatch"});
        end
    endtask

    task automatic check_framing(input string name, input ssb_sync_pkg::framed_strm_t got,
                                 input ssb_sync_pkg::framed_strm_t want);
        if ({got.valid, got.symbol_start, got.ssb_start} !==
            {want.valid, want.symbol_start, want.ssb_start}) begin
            $display("[FAIL] %0t %s valid/symbol/ssb got %b%b%b expected %b%b%b", $time, name,
                     got.valid, got.symbol_start, got.ssb_start,
                     want.valid, want.symbol_start, want.ssb_start);
            abort_run({name, " framing flags mismatch"});
        end
    endtask

    task automatic drive_sample(input int re, input int im);
        ssb_sync_pkg::sample_strm_t v;
        int                         gap;
        v.valid   = 1'b1;
        v.data.re = ssb_sync_pkg::iq_comp_t'(re);
        v.data.im = ssb_sync_pkg::iq_comp_t'(im);
        gap = $random(seed) & 7;
        if (gap > 3) begin
            gap = 0;
        end
        repeat (gap) begin   // Random valid gap
            @(posedge clk_i);
            s_i <= '0;
        end
        @(posedge clk_i);
        s_i <= v;
    endtask

    task automatic send_noise(input int count);
        int re;
        int im;
        for (int i = 0; i < count; i++) begin
            re = $random(seed) % NOISE_AMP;
            im = $random(seed) % NOISE_AMP;
            drive_sample(re, im);
        end
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin : stimulus
        int re;
        int wait_cnt;
        s_i <= '0;
        wait_cnt = 0;
        while (reset_ni !== 1'b1) begin
            @(posedge clk_i);
            wait_cnt++;
            if (wait_cnt > 10) begin
                abort_run("reset was never released");
            end
        end
        send_noise(200);   // Even count keeps the pattern on the decimation phase
        pattern_cyc = cyc;
        for (int j = ssb_sync_pkg::PSS_LEN - 1; j >= 0; j--) begin
            re = ssb_sync_pkg::PSS_TAPS[j] ? PSS_AMP : -PSS_AMP;
            drive_sample(re, -re);
            drive_sample(re, -re);
        end
        send_noise(400);
        @(posedge clk_i);
        s_i <= '0;
        wait_cnt = 0;
        while (exp_q.size() != 0 || frames_done == 0) begin
            @(posedge clk_i);
            wait_cnt++;
            if (wait_cnt > 1000) begin
                abort_run("timed out waiting for the framed SSB output");
            end
        end
        repeat (50) @(posedge clk_i);   // Output must stay quiet with no new peak
        if (peak_count > 0 && first_peak_cyc > pattern_cyc && framed_checked >= SSB_LEN) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            abort_run("no complete SSB followed the PSS, or noise alone raised a peak");
        end
    end

    // ----------------------------------------
    // Reference update and compare
    // ----------------------------------------
    always @(negedge clk_i) begin : compare
        ssb_sync_pkg::iq_sample_t   cic_d;
        ssb_sync_pkg::framed_strm_t want_f;
        framed_exp_t                head;
        bit                         cic_v;
        if (cyc >= MAX_CYC - 4) begin
            abort_run("cycle budget used up before the run completed");
        end
        cic_v = 1'b0;
        cic_d = '0;
        if (cyc > 0 && in_s[cyc-1].valid) begin   // Sample taken at the last edge
            xr[2] = xr[1];
            xr[1] = xr[0];
            xr[0] = in_s[cyc-1].data.re;
            xi[2] = xi[1];
            xi[1] = xi[0];
            xi[0] = in_s[cyc-1].data.im;
            n_in++;
            if (n_in % ssb_sync_pkg::CIC_RATE == 0) begin
                cic_v    = 1'b1;
                cic_d.re = cic_ref(xr[0], xr[1], xr[2]);
                cic_d.im = cic_ref(xi[0], xi[1], xi[2]);
            end
        end
        if (cic_v) begin
            for (int k = ssb_sync_pkg::PSS_LEN - 1; k > 0; k--) begin
                dr[k] = dr[k-1];
                di[k] = di[k-1];
            end
            dr[0]         = cic_d.re;
            di[0]         = cic_d.im;
            exp_mv[cyc+2] = 1'b1;
            exp_m[cyc+2]  = metric_ref();
        end
        if (exp_mv[cyc]) begin
            if (peak_ref(exp_m[cyc], since_peak)) begin
                exp_pk[cyc+1] = 1'b1;
                since_peak    = 0;
                peak_count++;
                if (first_peak_cyc < 0) begin
                    first_peak_cyc = cyc;
                end
            end else begin
                since_peak++;
            end
        end
        // Framing works on the input DELAY_LEN edges back
        if (!fr_active) begin
            fr_active = exp_pk[cyc];
        end else if (cyc >= ssb_sync_pkg::DELAY_LEN &&
                     in_s[cyc-ssb_sync_pkg::DELAY_LEN].valid) begin
            head.due              = cyc + 1;
            head.frm.data         = in_s[cyc-ssb_sync_pkg::DELAY_LEN].data;
            head.frm.valid        = 1'b1;
            head.frm.symbol_start = (fr_idx % ssb_sync_pkg::SYM_LEN == 0);
            head.frm.ssb_start    = (fr_idx == 0);
            exp_q.push_back(head);
            fr_idx++;
            if (fr_idx == SSB_LEN) begin
                fr_active = 1'b0;
                fr_idx    = 0;
                frames_done++;
            end
        end
        want_f = '0;
        if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
            head   = exp_q.pop_front();
            want_f = head.frm;
            framed_checked++;
        end
        check_strobe("cic_o.valid", cic_o.valid, cic_v);
        if (cic_v) begin
            check_sample("cic_o.data", cic_o.data, cic_d);
        end
        check_strobe("metric_valid_o", metric_valid_o, exp_mv[cyc]);
        if (exp_mv[cyc]) begin
            check_metric("metric_o", metric_o, exp_m[cyc]);
        end
        check_strobe("peak_o", peak_o, exp_pk[cyc]);
        check_framing("out_o", out_o, want_f);
        if (want_f.valid) begin
            check_sample("out_o.data", out_o.data, want_f.data);
        end
        in_s[cyc] = s_i;
        cyc++;
    end

endmodule

// File: project.f
common/ssb_sync_pkg.sv
source/cic_decimator.sv
pss_detector/pss_correlator.sv
pss_detector/pss_peak_detector.sv
source/sample_delay_line.sv
source/frame_sync.sv
source/ssb_sync_top.sv
testbench/clock_gen.sv
testbench/tb_ssb_sync_top.sv

// File: Bender.yml
package:
  name: ssb_sync

sources:
  - common/ssb_sync_pkg.sv
  - source/cic_decimator.sv
  - pss_detector/pss_correlator.sv
  - pss_detector/pss_peak_detector.sv
  - source/sample_delay_line.sv
  - source/frame_sync.sv
  - source/ssb_sync_top.sv
  - target: test
    files:
      - testbench/clock_gen.sv
      - testbench/tb_ssb_sync_top.sv
